//--- dv/idu_patterns.txt
# inst(hex) legal op rd rs1 rs2 (decimal) imm(hex)
# legal 0 lines must produce no output record
123452b7 1 0 5 0 0 12345000
fffff097 1 1 1 0 0 fffff000
ffdff0ef 1 2 1 0 0 fffffffc
ff818167 1 3 2 3 0 fffffff8
0ff0000f 0 0 0 0 0 00000000
fe208ce3 1 4 0 1 2 fffffff8
00419863 1 5 0 3 4 00000010
00002063 0 0 0 0 0 00000000
0062c263 1 6 0 5 6 00000004
0083d463 1 7 0 7 8 00000008
0020e663 1 8 0 1 2 0000000c
00a4f0e3 1 9 0 9 10 00000800
fff30283 1 10 5 6 0 ffffffff
00003003 0 0 0 0 0 00000000
00411083 1 11 1 2 0 00000004
00812503 1 12 10 2 0 00000008
00124183 1 13 3 4 0 00000001
0022d203 1 14 4 5 0 00000002
fe208e23 1 15 0 1 2 fffffffc
00003023 0 0 0 0 0 00000000
00321323 1 16 0 4 3 00000006
02532023 1 17 0 6 5 00000020
80000093 1 18 1 0 0 fffff800
0051a113 1 19 2 3 0 00000005
0012b213 1 20 4 5 0 00000001
fff3c313 1 21 6 7 0 ffffffff
0f04e413 1 22 8 9 0 000000f0
7ff5f513 1 23 10 11 0 000007ff
00311093 1 24 1 2 0 00000003
02005013 0 0 0 0 0 00000000
01f25193 1 25 3 4 0 0000001f
40735293 1 26 5 6 0 00000007
003100b3 1 27 1 2 3 00000000
02000033 0 0 0 0 0 00000000
40628233 1 28 4 5 6 00000000
009413b3 1 29 7 8 9 00000000
00c5a533 1 30 10 11 12 00000000
00f736b3 1 31 13 14 15 00000000
0128c833 1 32 16 17 18 00000000
00000073 0 0 0 0 0 00000000
003150b3 1 33 1 2 3 00000000
02005033 0 0 0 0 0 00000000
403150b3 1 34 1 2 3 00000000
015a69b3 1 35 19 20 21 00000000
01df7fb3 1 36 31 30 29 00000000

//--- dv/riscv_idu_chk.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_idu_chk
  import riscv_idu_pkg::*;
(
  input logic             clk,
  input logic             reset,
  input logic             out_valid,
  input logic             out_ready,
  input logic [OP_W-1:0]  out_op,
  input logic [REG_W-1:0] out_rd,
  input logic [REG_W-1:0] out_rs1,
  input logic [REG_W-1:0] out_rs2,
  input logic [XLEN-1:0]  out_imm
);

  // A stalled record must not change
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_op) && $stable(out_rd) &&
      $stable(out_rs1) && $stable(out_rs2) && $stable(out_imm))
    else $error("Output record changed while out_ready was low");

  a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  a_op_known: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> !$isunknown(out_op))
    else $error("out_op unknown while out_valid is high");

endmodule

`default_nettype wire

//--- dv/riscv_idu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_idu_tb
  import riscv_idu_pkg::*;
();

  localparam int TIMEOUT = 400;  // Cycles per wait

  logic             clk;
  logic             reset;
  logic             in_valid;
  logic [XLEN-1:0]  in_inst;
  logic             in_ready;
  logic             out_valid;
  logic             out_ready;
  logic [OP_W-1:0]  out_op;
  logic [REG_W-1:0] out_rd;
  logic [REG_W-1:0] out_rs1;
  logic [REG_W-1:0] out_rs2;
  logic [XLEN-1:0]  out_imm;

  logic [XLEN-1:0]  pat_inst[$];
  bit               pat_legal[$];
  logic [OP_W-1:0]  exp_op[$];
  logic [REG_W-1:0] exp_rd[$];
  logic [REG_W-1:0] exp_rs1[$];
  logic [REG_W-1:0] exp_rs2[$];
  logic [XLEN-1:0]  exp_imm[$];

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cyc          = 0;
  int rec_cnt      = 0;
  int first_acc    = -1;
  int first_out    = -1;
  int last_out     = -1;
  int full_stalls  = 0;
  bit gap_check    = 1'b0;
  bit stall_en     = 1'b0;
  bit hung         = 1'b0;  // Set once any wait has timed out

  riscv_idu dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_inst   (in_inst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_op    (out_op),
    .out_rd    (out_rd),
    .out_rs1   (out_rs1),
    .out_rs2   (out_rs2),
    .out_imm   (out_imm)
  );

  bind riscv_idu riscv_idu_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_op    (out_op),
    .out_rd    (out_rd),
    .out_rs1   (out_rs1),
    .out_rs2   (out_rs2),
    .out_imm   (out_imm)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Sink side with random stalls when enabled
  initial begin
    void'($urandom(48708));
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (stall_en) out_ready = ($urandom % 2) == 0;
      else out_ready = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [XLEN-1:0] act,
                             input logic [XLEN-1:0] exp);
    if (act !== exp) begin
      $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_record();
    if (rec_cnt >= exp_op.size()) begin
      $display("An extra output record came out beyond the %0d expected", exp_op.size());
      errors++;
    end else begin
      check_value("out_op", XLEN'(out_op), XLEN'(exp_op[rec_cnt]));
      check_value("out_rd", XLEN'(out_rd), XLEN'(exp_rd[rec_cnt]));
      check_value("out_rs1", XLEN'(out_rs1), XLEN'(exp_rs1[rec_cnt]));
      check_value("out_rs2", XLEN'(out_rs2), XLEN'(exp_rs2[rec_cnt]));
      check_value("out_imm", out_imm, exp_imm[rec_cnt]);
    end
    if (first_out < 0) first_out = cyc;
    else if (gap_check && cyc != last_out + 1) begin
      $display("Output stream had a gap after record %0d", rec_cnt);
      errors++;
    end
    last_out = cyc;
    rec_cnt++;
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!reset) begin
      if (in_valid && in_ready && first_acc < 0) first_acc = cyc;
      if (dut.s1_valid && dut.s2_valid && out_valid && !out_ready) begin
        full_stalls++;
        if (in_ready) begin
          $display("ERROR in_ready: expected 0x0, got 0x1");
          errors++;
        end
      end
      if (out_valid && out_ready) check_record();
    end
  end

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    errors++;
    hung = 1'b1;
  endtask

  task automatic load_patterns();
    int              fd;
    int              n;
    string           line;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] imm;
    int              legal;
    int              op;
    int              rd;
    int              rs1;
    int              rs2;
    fd = $fopen("dv/idu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file dv/idu_patterns.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %d %d %d %d %d %h", word, legal, op, rd, rs1, rs2, imm);
          if (n == 7) begin
            pat_inst.push_back(word);
            pat_legal.push_back(legal != 0);
            if (legal != 0) begin
              exp_op.push_back(op[OP_W-1:0]);
              exp_rd.push_back(rd[REG_W-1:0]);
              exp_rs1.push_back(rs1[REG_W-1:0]);
              exp_rs2.push_back(rs2[REG_W-1:0]);
              exp_imm.push_back(imm);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Holds the word until the DUT takes it
  task automatic drive_word(input logic [XLEN-1:0] word);
    int waited;
    bit taken;
    waited = 0;
    taken = 1'b0;
    in_valid = 1'b1;
    in_inst = word;
    while (!taken && !hung) begin
      if (waited > TIMEOUT) report_timeout("in_ready stayed low while sending a word");
      else begin
        @(posedge clk);
        taken = in_ready;
        #2;
        waited++;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!hung &&
           (rec_cnt < exp_op.size() || dut.s1_valid || dut.s2_valid || out_valid)) begin
      if (waited > TIMEOUT) report_timeout("expected records did not all come out");
      else begin
        @(posedge clk);
        #2;
        waited++;
      end
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests_run++;
    if (errors == start_err && !hung) begin
      $display("Test %s: ok, %0d records", name, rec_cnt);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, errors - start_err);
    end
  endtask

  task automatic run_stream(input string name, input bit with_illegal, input bit stall,
                            input bit timing);
    int start_err;
    start_err = errors;
    rec_cnt = 0;
    first_acc = -1;
    first_out = -1;
    last_out = -1;
    full_stalls = 0;
    stall_en = stall;
    gap_check = !stall && !with_illegal;
    foreach (pat_inst[i]) begin
      if (with_illegal || pat_legal[i]) drive_word(pat_inst[i]);
    end
    in_valid = 1'b0;
    wait_drain();
    stall_en = 1'b0;
    if (timing && first_out - first_acc != 3) begin
      $display("First record came %0d cycles after the first accept, not 3",
               first_out - first_acc);
      errors++;
    end
    if (stall && full_stalls == 0) begin
      $display("The pipeline never filled up under back-pressure");
      errors++;
    end
    report_test(name, start_err);
  endtask

  initial begin
    int start_err;
    reset = 1'b1;
    in_valid = 1'b0;
    in_inst = '0;
    load_patterns();
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    start_err = errors;
    if (out_valid !== 1'b0) begin
      $display("ERROR out_valid: expected 0x0, got 0x%h", out_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("ERROR in_ready: expected 0x1, got 0x%h", in_ready);
      errors++;
    end
    report_test("reset", start_err);

    run_stream("legal_decode", 1'b0, 1'b0, 1'b0);
    run_stream("illegal_drop", 1'b1, 1'b0, 1'b0);
    run_stream("latency_throughput", 1'b0, 1'b0, 1'b1);
    run_stream("back_pressure", 1'b1, 1'b1, 1'b0);

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/idu_format_stage.sv
`timescale 1ns/10ps
`default_nettype none

module idu_format_stage
  import riscv_idu_pkg::*;
(
  input  logic             clk,
  input  logic             reset,

  input  logic             in_valid,
  input  logic [XLEN-1:0]  in_inst,
  output logic             in_ready,

  output logic             s1_valid,
  input  logic             s1_ready,
  output logic [FMT_W-1:0] s1_fmt,
  output inst_u            s1_inst
);

  logic [FMT_W-1:0] fmt;
  logic             known;
  logic             load;

  always_comb begin
    fmt   = FMT_R;
    known = 1'b1;
    case (in_inst[OPC_W-1:0])
      OPC_LUI,
      OPC_AUIPC:  fmt = FMT_U;
      OPC_JAL:    fmt = FMT_J;
      OPC_JALR,
      OPC_LOAD,
      OPC_OPIMM:  fmt = FMT_I;
      OPC_BRANCH: fmt = FMT_B;
      OPC_STORE:  fmt = FMT_S;
      OPC_OP:     fmt = FMT_R;
      default:    known = 1'b0;  // Includes FENCE and SYSTEM
    endcase
  end

  assign in_ready = !s1_valid || s1_ready;
  assign load     = in_valid && in_ready && known;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (in_ready) begin
      s1_valid <= in_valid && known;  // Unknown opcode leaves a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      s1_fmt  <= fmt;
      s1_inst <= in_inst;
    end
  end

endmodule

`default_nettype wire

//--- hdl/idu_imm_stage.sv
`timescale 1ns/10ps
`default_nettype none

module idu_imm_stage
  import riscv_idu_pkg::*;
(
  input  logic             clk,
  input  logic             reset,

  input  logic             s2_valid,
  output logic             s2_ready,
  input  logic [FMT_W-1:0] s2_fmt,
  input  inst_u            s2_inst,
  input  logic [OP_W-1:0]  s2_op,
  input  logic [REG_W-1:0] s2_rd,
  input  logic [REG_W-1:0] s2_rs1,
  input  logic [REG_W-1:0] s2_rs2,

  output logic             out_valid,
  input  logic             out_ready,
  output logic [OP_W-1:0]  out_op,
  output logic [REG_W-1:0] out_rd,
  output logic [REG_W-1:0] out_rs1,
  output logic [REG_W-1:0] out_rs2,
  output logic [XLEN-1:0]  out_imm
);

  logic [XLEN-1:0] imm;

  always_comb begin
    case (s2_fmt)
      FMT_I:  imm = {{(XLEN-12){s2_inst.i.imm_11_0[11]}}, s2_inst.i.imm_11_0};
      FMT_S:  imm = {{(XLEN-12){s2_inst.s.imm_11_5[6]}}, s2_inst.s.imm_11_5,
                     s2_inst.s.imm_4_0};
      FMT_B:  imm = {{(XLEN-12){s2_inst.b.imm_12}}, s2_inst.b.imm_11,
                     s2_inst.b.imm_10_5, s2_inst.b.imm_4_1, 1'b0};
      FMT_U:  imm = {s2_inst.u.imm_31_12, 12'b0};
      FMT_J:  imm = {{(XLEN-20){s2_inst.j.imm_20}}, s2_inst.j.imm_19_12,
                     s2_inst.j.imm_11, s2_inst.j.imm_10_1, 1'b0};
      FMT_SH: imm = {{(XLEN-REG_W){1'b0}}, s2_inst.r.rs2};  // Shift amount
      default: imm = '0;  // R-type has none
    endcase
  end

  assign s2_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (s2_ready) begin
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid && s2_ready) begin
      out_op  <= s2_op;
      out_rd  <= s2_rd;
      out_rs1 <= s2_rs1;
      out_rs2 <= s2_rs2;
      out_imm <= imm;
    end
  end

endmodule

`default_nettype wire

//--- hdl/idu_op_stage.sv
`timescale 1ns/10ps
`default_nettype none

module idu_op_stage
  import riscv_idu_pkg::*;
(
  input  logic             clk,
  input  logic             reset,

  input  logic             s1_valid,
  output logic             s1_ready,
  input  logic [FMT_W-1:0] s1_fmt,
  input  inst_u            s1_inst,

  output logic             s2_valid,
  input  logic             s2_ready,
  output logic [FMT_W-1:0] s2_fmt,
  output inst_u            s2_inst,
  output logic [OP_W-1:0]  s2_op,
  output logic [REG_W-1:0] s2_rd,
  output logic [REG_W-1:0] s2_rs1,
  output logic [REG_W-1:0] s2_rs2
);

  logic [OP_W-1:0]  op;
  logic [FMT_W-1:0] fmt;
  logic             legal;
  logic [REG_W-1:0] rd;
  logic [REG_W-1:0] rs1;
  logic [REG_W-1:0] rs2;

  always_comb begin
    op    = OP_LUI;
    fmt   = s1_fmt;
    legal = 1'b1;
    case (s1_inst.r.opcode)
      OPC_LUI:   op = OP_LUI;
      OPC_AUIPC: op = OP_AUIPC;
      OPC_JAL:   op = OP_JAL;
      OPC_JALR:  op = OP_JALR;
      OPC_BRANCH: begin
        case (s1_inst.r.funct3)
          3'b000:  op = OP_BEQ;
          3'b001:  op = OP_BNE;
          3'b100:  op = OP_BLT;
          3'b101:  op = OP_BGE;
          3'b110:  op = OP_BLTU;
          3'b111:  op = OP_BGEU;
          default: legal = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        case (s1_inst.r.funct3)
          3'b000:  op = OP_LB;
          3'b001:  op = OP_LH;
          3'b010:  op = OP_LW;
          3'b100:  op = OP_LBU;
          3'b101:  op = OP_LHU;
          default: legal = 1'b0;
        endcase
      end
      OPC_STORE: begin
        case (s1_inst.r.funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          default: legal = 1'b0;
        endcase
      end
      OPC_OPIMM: begin
        case (s1_inst.r.funct3)
          3'b000: op = OP_ADDI;
          3'b010: op = OP_SLTI;
          3'b011: op = OP_SLTIU;
          3'b100: op = OP_XORI;
          3'b110: op = OP_ORI;
          3'b111: op = OP_ANDI;
          3'b001: begin
            op  = OP_SLLI;
            fmt = FMT_SH;
          end
          default: begin  // SRLI or SRAI
            fmt   = FMT_SH;
            op    = (s1_inst.r.funct7 == F7_ALT) ? OP_SRAI : OP_SRLI;
            legal = (s1_inst.r.funct7 == F7_BASE) || (s1_inst.r.funct7 == F7_ALT);
          end
        endcase
      end
      OPC_OP: begin
        case (s1_inst.r.funct3)
          3'b000: begin
            op    = (s1_inst.r.funct7 == F7_ALT) ? OP_SUB : OP_ADD;
            legal = (s1_inst.r.funct7 == F7_BASE) || (s1_inst.r.funct7 == F7_ALT);
          end
          3'b001: op = OP_SLL;
          3'b010: op = OP_SLT;
          3'b011: op = OP_SLTU;
          3'b100: op = OP_XOR;
          3'b101: begin
            op    = (s1_inst.r.funct7 == F7_ALT) ? OP_SRA : OP_SRL;
            legal = (s1_inst.r.funct7 == F7_BASE) || (s1_inst.r.funct7 == F7_ALT);
          end
          3'b110: op = OP_OR;
          default: op = OP_AND;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // Fields a format does not carry leave as zero
  assign rd  = (s1_fmt == FMT_B || s1_fmt == FMT_S) ? '0 : s1_inst.r.rd;
  assign rs1 = (s1_fmt == FMT_U || s1_fmt == FMT_J) ? '0 : s1_inst.r.rs1;
  assign rs2 = (s1_fmt == FMT_R || s1_fmt == FMT_S || s1_fmt == FMT_B) ?
               s1_inst.r.rs2 : '0;

  assign s1_ready = !s2_valid || s2_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (s1_ready) begin
      s2_valid <= s1_valid && legal;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s1_ready && legal) begin
      s2_fmt  <= fmt;
      s2_inst <= s1_inst;
      s2_op   <= op;
      s2_rd   <= rd;
      s2_rs1  <= rs1;
      s2_rs2  <= rs2;
    end
  end

endmodule

`default_nettype wire

//--- hdl/riscv_idu.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_idu
  import riscv_idu_pkg::*;
(
  input  logic             clk,
  input  logic             reset,

  input  logic             in_valid,
  input  logic [XLEN-1:0]  in_inst,
  output logic             in_ready,

  output logic             out_valid,
  input  logic             out_ready,
  output logic [OP_W-1:0]  out_op,
  output logic [REG_W-1:0] out_rd,
  output logic [REG_W-1:0] out_rs1,
  output logic [REG_W-1:0] out_rs2,
  output logic [XLEN-1:0]  out_imm
);

  logic             s1_valid;
  logic             s1_ready;
  logic [FMT_W-1:0] s1_fmt;
  inst_u            s1_inst;

  logic             s2_valid;
  logic             s2_ready;
  logic [FMT_W-1:0] s2_fmt;
  inst_u            s2_inst;
  logic [OP_W-1:0]  s2_op;
  logic [REG_W-1:0] s2_rd;
  logic [REG_W-1:0] s2_rs1;
  logic [REG_W-1:0] s2_rs2;

  idu_format_stage u_format (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_ready (in_ready),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_fmt   (s1_fmt),
    .s1_inst  (s1_inst)
  );

  idu_op_stage u_op (
    .clk      (clk),
    .reset    (reset),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_fmt   (s1_fmt),
    .s1_inst  (s1_inst),
    .s2_valid (s2_valid),
    .s2_ready (s2_ready),
    .s2_fmt   (s2_fmt),
    .s2_inst  (s2_inst),
    .s2_op    (s2_op),
    .s2_rd    (s2_rd),
    .s2_rs1   (s2_rs1),
    .s2_rs2   (s2_rs2)
  );

  idu_imm_stage u_imm (
    .clk       (clk),
    .reset     (reset),
    .s2_valid  (s2_valid),
    .s2_ready  (s2_ready),
    .s2_fmt    (s2_fmt),
    .s2_inst   (s2_inst),
    .s2_op     (s2_op),
    .s2_rd     (s2_rd),
    .s2_rs1    (s2_rs1),
    .s2_rs2    (s2_rs2),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_op    (out_op),
    .out_rd    (out_rd),
    .out_rs1   (out_rs1),
    .out_rs2   (out_rs2),
    .out_imm   (out_imm)
  );

endmodule

`default_nettype wire

//--- hdl/riscv_idu_pkg.sv
`default_nettype none

package riscv_idu_pkg;

  localparam int XLEN  = 32;
  localparam int REG_W = 5;
  localparam int OPC_W = 7;
  localparam int F3_W  = 3;
  localparam int F7_W  = 7;

  localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPC_W-1:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;

  localparam logic [F7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [F7_W-1:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

  localparam int FMT_W = 3;

  localparam logic [FMT_W-1:0] FMT_R  = 3'd0;
  localparam logic [FMT_W-1:0] FMT_I  = 3'd1;
  localparam logic [FMT_W-1:0] FMT_S  = 3'd2;
  localparam logic [FMT_W-1:0] FMT_B  = 3'd3;
  localparam logic [FMT_W-1:0] FMT_U  = 3'd4;
  localparam logic [FMT_W-1:0] FMT_J  = 3'd5;
  localparam logic [FMT_W-1:0] FMT_SH = 3'd6;  // Set by stage 2 only

  localparam int OP_W = 6;

  localparam logic [OP_W-1:0] OP_LUI   = 6'd0;
  localparam logic [OP_W-1:0] OP_AUIPC = 6'd1;
  localparam logic [OP_W-1:0] OP_JAL   = 6'd2;
  localparam logic [OP_W-1:0] OP_JALR  = 6'd3;
  localparam logic [OP_W-1:0] OP_BEQ   = 6'd4;
  localparam logic [OP_W-1:0] OP_BNE   = 6'd5;
  localparam logic [OP_W-1:0] OP_BLT   = 6'd6;
  localparam logic [OP_W-1:0] OP_BGE   = 6'd7;
  localparam logic [OP_W-1:0] OP_BLTU  = 6'd8;
  localparam logic [OP_W-1:0] OP_BGEU  = 6'd9;
  localparam logic [OP_W-1:0] OP_LB    = 6'd10;
  localparam logic [OP_W-1:0] OP_LH    = 6'd11;
  localparam logic [OP_W-1:0] OP_LW    = 6'd12;
  localparam logic [OP_W-1:0] OP_LBU   = 6'd13;
  localparam logic [OP_W-1:0] OP_LHU   = 6'd14;
  localparam logic [OP_W-1:0] OP_SB    = 6'd15;
  localparam logic [OP_W-1:0] OP_SH    = 6'd16;
  localparam logic [OP_W-1:0] OP_SW    = 6'd17;
  localparam logic [OP_W-1:0] OP_ADDI  = 6'd18;
  localparam logic [OP_W-1:0] OP_SLTI  = 6'd19;
  localparam logic [OP_W-1:0] OP_SLTIU = 6'd20;
  localparam logic [OP_W-1:0] OP_XORI  = 6'd21;
  localparam logic [OP_W-1:0] OP_ORI   = 6'd22;
  localparam logic [OP_W-1:0] OP_ANDI  = 6'd23;
  localparam logic [OP_W-1:0] OP_SLLI  = 6'd24;
  localparam logic [OP_W-1:0] OP_SRLI  = 6'd25;
  localparam logic [OP_W-1:0] OP_SRAI  = 6'd26;
  localparam logic [OP_W-1:0] OP_ADD   = 6'd27;
  localparam logic [OP_W-1:0] OP_SUB   = 6'd28;
  localparam logic [OP_W-1:0] OP_SLL   = 6'd29;
  localparam logic [OP_W-1:0] OP_SLT   = 6'd30;
  localparam logic [OP_W-1:0] OP_SLTU  = 6'd31;
  localparam logic [OP_W-1:0] OP_XOR   = 6'd32;
  localparam logic [OP_W-1:0] OP_SRL   = 6'd33;
  localparam logic [OP_W-1:0] OP_SRA   = 6'd34;
  localparam logic [OP_W-1:0] OP_OR    = 6'd35;
  localparam logic [OP_W-1:0] OP_AND   = 6'd36;

  // One instruction word, viewed per format
  typedef union packed {
    struct packed {
      logic [F7_W-1:0]  funct7;
      logic [REG_W-1:0] rs2;  // Also shamt for shift-immediates
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [REG_W-1:0] rd;
      logic [OPC_W-1:0] opcode;
    } r;
    struct packed {
      logic [11:0]      imm_11_0;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [REG_W-1:0] rd;
      logic [OPC_W-1:0] opcode;
    } i;
    struct packed {
      logic [6:0]       imm_11_5;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [4:0]       imm_4_0;
      logic [OPC_W-1:0] opcode;
    } s;
    struct packed {
      logic             imm_12;
      logic [5:0]       imm_10_5;
      logic [REG_W-1:0] rs2;
      logic [REG_W-1:0] rs1;
      logic [F3_W-1:0]  funct3;
      logic [3:0]       imm_4_1;
      logic             imm_11;
      logic [OPC_W-1:0] opcode;
    } b;
    struct packed {
      logic [19:0]      imm_31_12;
      logic [REG_W-1:0] rd;
      logic [OPC_W-1:0] opcode;
    } u;
    struct packed {
      logic             imm_20;
      logic [9:0]       imm_10_1;
      logic             imm_11;
      logic [7:0]       imm_19_12;
      logic [REG_W-1:0] rd;
      logic [OPC_W-1:0] opcode;
    } j;
  } inst_u;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module riscv_idu_tb \
  -o sim_riscv_idu
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_riscv_idu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

//--- verilog.f
hdl/riscv_idu_pkg.sv
hdl/idu_format_stage.sv
hdl/idu_op_stage.sv
hdl/idu_imm_stage.sv
hdl/riscv_idu.sv
dv/riscv_idu_chk.sv
dv/riscv_idu_tb.sv
